/* matrix_c_config.svh */
`ifndef MATRIX_C_CONFIG_SVH
`define MATRIX_C_CONFIG_SVH

// element and cache line geometry
`define MC_ELEM_BITS 32
`define MC_LINE_BITS 512
`define MC_LINE_ELEMS 16

// row and column index width
`define MC_INDEX_BITS 16

// element count of one read from 1 to 16
`define MC_SIZE_BITS 5

// byte address width
`define MC_ADDR_BITS 64

// queue depths
`define MC_JOB_DEPTH 32
`define MC_CMD_DEPTH 4

`endif

/* matrix_c_pkg.sv */
`include "matrix_c_config.svh"

package matrix_c_pkg;

    // one row or column position inside matrix C
    typedef logic [`MC_INDEX_BITS-1:0] index_t;

    typedef logic [`MC_ELEM_BITS-1:0] element_t;

    typedef logic [`MC_LINE_BITS-1:0] line_t;

    // unpacked element tagged with its position
    typedef struct packed {
        index_t   ii;
        index_t   jj;
        element_t data;
    } job_t;

    // walker FSM
    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_BOUNDS,
        WALK_SETUP,
        WALK_ISSUE,
        WALK_WAIT_LINE,
        WALK_NEXT_CHUNK
    } walker_state_t;

endpackage

/* mem_cmd_pkg.sv */
`include "matrix_c_config.svh"

package mem_cmd_pkg;

    // byte address into shared memory
    typedef logic [`MC_ADDR_BITS-1:0] address_t;

    // number of elements moved by one read
    typedef logic [`MC_SIZE_BITS-1:0] size_t;

    // read command as it waits in the command queue
    // ii and jj come back with the response
    typedef struct packed {
        address_t             address;
        size_t                real_size;
        matrix_c_pkg::index_t ii;
        matrix_c_pkg::index_t jj;
    } read_cmd_t;

endpackage

/* matrix_c_ifs.sv */
`include "matrix_c_config.svh"

// read command from the walker towards the command queue
interface read_cmd_if;
    logic                  valid;
    mem_cmd_pkg::address_t address;
    mem_cmd_pkg::size_t    real_size;
    matrix_c_pkg::index_t  ii;
    matrix_c_pkg::index_t  jj;

    modport walker (output valid, output address, output real_size, output ii, output jj);
    modport queue (input valid, input address, input real_size, input ii, input jj);
endinterface

// element stream out of the line unpacker
interface element_if;
    logic                   valid;
    matrix_c_pkg::index_t   ii;
    matrix_c_pkg::index_t   jj;
    matrix_c_pkg::element_t data;
    // final element of the current line
    logic                   last;

    modport unpacker (output valid, output ii, output jj, output data, output last);
    modport sink (input valid, input ii, input jj, input data, input last);
endinterface

/* sync_fifo.sv */
module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                       clock,
    input  logic                       rstn,
    input  logic                       push,
    input  payload_t                   data_in,
    input  logic                       pop,
    output payload_t                   data_out,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // payload storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head shown ahead of the pop
    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == ($clog2(DEPTH+1))'(DEPTH));

endmodule

/* tile_walker.sv */
`include "matrix_c_config.svh"

module tile_walker (
    input  logic                               clock,
    input  logic                               rstn,
    input  logic                               start,
    input  mem_cmd_pkg::address_t              base_address,
    input  matrix_c_pkg::index_t               size_n,
    input  matrix_c_pkg::index_t               size_tile,
    input  matrix_c_pkg::index_t               ii_start,
    input  matrix_c_pkg::index_t               jj_start,
    input  logic                               cmd_queue_empty,
    input  logic [$clog2(`MC_JOB_DEPTH+1)-1:0] job_count,
    element_if.sink                            elem,
    read_cmd_if.walker                         cmd,
    output logic                               busy,
    output logic                               done
);

    localparam matrix_c_pkg::index_t LINE_STEP = `MC_LINE_ELEMS;
    localparam int JOB_ROOM_MAX = `MC_JOB_DEPTH - `MC_LINE_ELEMS;

    matrix_c_pkg::walker_state_t state;
    mem_cmd_pkg::address_t       base_q;
    mem_cmd_pkg::address_t       elem_offset;
    matrix_c_pkg::index_t        size_n_q, size_tile_q, ii_start_q, jj_start_q;
    matrix_c_pkg::index_t        ii_end, jj_end, ii_cur, jj_cur, cols_left;
    logic [`MC_INDEX_BITS:0]     ii_limit, jj_limit;
    logic                        line_done, last_chunk, room;

////////////////////////////////////////////////////////////////////////////
// tile description and bounds
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (state == matrix_c_pkg::WALK_IDLE && start) begin
            base_q      <= base_address;
            size_n_q    <= size_n;
            size_tile_q <= size_tile;
            ii_start_q  <= ii_start;
            jj_start_q  <= jj_start;
        end
        // clip the tile at the matrix edge
        if (state == matrix_c_pkg::WALK_BOUNDS) begin
            ii_end <= (ii_limit < size_n_q) ? ii_limit[`MC_INDEX_BITS-1:0] : size_n_q;
            jj_end <= (jj_limit < size_n_q) ? jj_limit[`MC_INDEX_BITS-1:0] : size_n_q;
        end
    end

    assign ii_limit = {1'b0, ii_start_q} + {1'b0, size_tile_q};
    assign jj_limit = {1'b0, jj_start_q} + {1'b0, size_tile_q};

////////////////////////////////////////////////////////////////////////////
// walk FSM
////////////////////////////////////////////////////////////////////////////

    assign cols_left  = jj_end - jj_cur;
    assign line_done  = elem.valid && elem.last;
    assign last_chunk = (cols_left <= LINE_STEP) && ((ii_end - ii_cur) == 1);
    // a whole line must fit into the job FIFO
    assign room       = cmd_queue_empty && (job_count <= JOB_ROOM_MAX);

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            state  <= matrix_c_pkg::WALK_IDLE;
            ii_cur <= '0;
            jj_cur <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                matrix_c_pkg::WALK_IDLE: begin
                    if (start) begin
                        state <= matrix_c_pkg::WALK_BOUNDS;
                    end
                end
                matrix_c_pkg::WALK_BOUNDS: begin
                    state <= matrix_c_pkg::WALK_SETUP;
                end
                matrix_c_pkg::WALK_SETUP: begin
                    ii_cur <= ii_start_q;
                    jj_cur <= jj_start_q;
                    // tile lies outside the matrix
                    if (ii_end <= ii_start_q || jj_end <= jj_start_q) begin
                        done  <= 1'b1;
                        state <= matrix_c_pkg::WALK_IDLE;
                    end else begin
                        state <= matrix_c_pkg::WALK_ISSUE;
                    end
                end
                matrix_c_pkg::WALK_ISSUE: begin
                    if (room) begin
                        state <= matrix_c_pkg::WALK_WAIT_LINE;
                    end
                end
                matrix_c_pkg::WALK_WAIT_LINE: begin
                    if (line_done && last_chunk) begin
                        done  <= 1'b1;
                        state <= matrix_c_pkg::WALK_IDLE;
                    end else if (line_done) begin
                        state <= matrix_c_pkg::WALK_NEXT_CHUNK;
                    end
                end
                matrix_c_pkg::WALK_NEXT_CHUNK: begin
                    if (cols_left > LINE_STEP) begin
                        jj_cur <= jj_cur + LINE_STEP;
                    end else begin
                        jj_cur <= jj_start_q;
                        ii_cur <= ii_cur + 1'b1;
                    end
                    state <= matrix_c_pkg::WALK_ISSUE;
                end
                default: state <= matrix_c_pkg::WALK_IDLE;
            endcase
        end
    end

    // word offset of the first element
    assign elem_offset = mem_cmd_pkg::address_t'(ii_cur) * mem_cmd_pkg::address_t'(size_n_q)
                       + mem_cmd_pkg::address_t'(jj_cur);

    assign cmd.valid     = (state == matrix_c_pkg::WALK_ISSUE) && room;
    assign cmd.address   = base_q + (elem_offset << $clog2(`MC_ELEM_BITS/8));
    assign cmd.real_size = (cols_left > LINE_STEP) ? mem_cmd_pkg::size_t'(`MC_LINE_ELEMS)
                                                   : cols_left[`MC_SIZE_BITS-1:0];
    assign cmd.ii        = ii_cur;
    assign cmd.jj        = jj_cur;
    assign busy          = (state != matrix_c_pkg::WALK_IDLE);

endmodule

/* line_unpacker.sv */
`include "matrix_c_config.svh"

module line_unpacker (
    input  logic                 clock,
    input  logic                 rstn,
    input  logic                 resp_valid,
    input  matrix_c_pkg::line_t  resp_line,
    input  mem_cmd_pkg::size_t   resp_real_size,
    input  matrix_c_pkg::index_t resp_ii,
    input  matrix_c_pkg::index_t resp_jj,
    element_if.unpacker          elem
);

    matrix_c_pkg::line_t  shift_q;
    mem_cmd_pkg::size_t   left_q;
    matrix_c_pkg::index_t ii_q;
    matrix_c_pkg::index_t jj_q;

    // memory words arrive in the other byte order
    function automatic matrix_c_pkg::element_t swap_bytes(input matrix_c_pkg::element_t value);
        matrix_c_pkg::element_t swapped;
        for (int b = 0; b < `MC_ELEM_BITS/8; b++) begin
            swapped[8*b +: 8] = value[`MC_ELEM_BITS-8-8*b +: 8];
        end
        return swapped;
    endfunction

////////////////////////////////////////////////////////////////////////////
// element counter
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            left_q <= '0;
        end else if (resp_valid) begin
            left_q <= resp_real_size;
        end else if (left_q != '0) begin
            left_q <= left_q - 1'b1;
        end
    end

////////////////////////////////////////////////////////////////////////////
// line shift register
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (resp_valid) begin
            shift_q <= resp_line;
            ii_q    <= resp_ii;
            jj_q    <= resp_jj;
        end else if (left_q != '0) begin
            // next element moves up to the top slot
            shift_q <= shift_q << `MC_ELEM_BITS;
            jj_q    <= jj_q + 1'b1;
        end
    end

    assign elem.valid = (left_q != '0);
    assign elem.last  = (left_q == mem_cmd_pkg::size_t'(1));
    assign elem.ii    = ii_q;
    assign elem.jj    = jj_q;
    assign elem.data  = swap_bytes(shift_q[`MC_LINE_BITS-1 -: `MC_ELEM_BITS]);

endmodule

/* matrix_c_job_control.sv */
`include "matrix_c_config.svh"

module matrix_c_job_control (
    input  logic                   clock,
    input  logic                   rstn,
    input  logic                   start,
    input  mem_cmd_pkg::address_t  base_address,
    input  matrix_c_pkg::index_t   size_n,
    input  matrix_c_pkg::index_t   size_tile,
    input  matrix_c_pkg::index_t   ii_start,
    input  matrix_c_pkg::index_t   jj_start,
    output logic                   busy,
    output logic                   done,
    // read command queue
    output logic                   cmd_request,
    input  logic                   cmd_grant,
    output mem_cmd_pkg::address_t  cmd_address,
    output mem_cmd_pkg::size_t     cmd_real_size,
    output matrix_c_pkg::index_t   cmd_ii,
    output matrix_c_pkg::index_t   cmd_jj,
    // read response of one full line
    input  logic                   resp_valid,
    input  matrix_c_pkg::line_t    resp_line,
    input  mem_cmd_pkg::size_t     resp_real_size,
    input  matrix_c_pkg::index_t   resp_ii,
    input  matrix_c_pkg::index_t   resp_jj,
    // job queue
    output logic                   job_empty,
    input  logic                   job_pop,
    output matrix_c_pkg::index_t   job_ii,
    output matrix_c_pkg::index_t   job_jj,
    output matrix_c_pkg::element_t job_data
);

    read_cmd_if rd_cmd ();
    element_if  elem_bus ();

    mem_cmd_pkg::read_cmd_t             cmd_in, cmd_head;
    matrix_c_pkg::job_t                 job_in, job_head;
    logic                               cmd_empty;
    logic [$clog2(`MC_JOB_DEPTH+1)-1:0] job_count;

////////////////////////////////////////////////////////////////////////////
// command path
////////////////////////////////////////////////////////////////////////////

    tile_walker walker (
        .clock           (clock),
        .rstn            (rstn),
        .start           (start),
        .base_address    (base_address),
        .size_n          (size_n),
        .size_tile       (size_tile),
        .ii_start        (ii_start),
        .jj_start        (jj_start),
        .cmd_queue_empty (cmd_empty),
        .job_count       (job_count),
        .elem            (elem_bus.sink),
        .cmd             (rd_cmd.walker),
        .busy            (busy),
        .done            (done)
    );

    assign cmd_in = '{address: rd_cmd.address, real_size: rd_cmd.real_size,
                      ii: rd_cmd.ii, jj: rd_cmd.jj};

    sync_fifo #(.payload_t(mem_cmd_pkg::read_cmd_t), .DEPTH(`MC_CMD_DEPTH)) cmd_fifo (
        .clock    (clock),
        .rstn     (rstn),
        .push     (rd_cmd.valid),
        .data_in  (cmd_in),
        .pop      (cmd_grant),
        .data_out (cmd_head),
        .empty    (cmd_empty),
        .full     (),
        .count    ()
    );

    assign cmd_request   = !cmd_empty;
    assign cmd_address   = cmd_head.address;
    assign cmd_real_size = cmd_head.real_size;
    assign cmd_ii        = cmd_head.ii;
    assign cmd_jj        = cmd_head.jj;

////////////////////////////////////////////////////////////////////////////
// response and job path
////////////////////////////////////////////////////////////////////////////

    line_unpacker unpacker (
        .clock          (clock),
        .rstn           (rstn),
        .resp_valid     (resp_valid),
        .resp_line      (resp_line),
        .resp_real_size (resp_real_size),
        .resp_ii        (resp_ii),
        .resp_jj        (resp_jj),
        .elem           (elem_bus.unpacker)
    );

    assign job_in = '{ii: elem_bus.ii, jj: elem_bus.jj, data: elem_bus.data};

    sync_fifo #(.payload_t(matrix_c_pkg::job_t), .DEPTH(`MC_JOB_DEPTH)) job_fifo (
        .clock    (clock),
        .rstn     (rstn),
        .push     (elem_bus.valid),
        .data_in  (job_in),
        .pop      (job_pop),
        .data_out (job_head),
        .empty    (job_empty),
        .full     (),
        .count    (job_count)
    );

    assign job_ii   = job_head.ii;
    assign job_jj   = job_head.jj;
    assign job_data = job_head.data;

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clock,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam time PERIOD       = 100ns;
    localparam int  RESET_CYCLES = 8;

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // reset released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rstn = 1'b1;
    end

endmodule

/* tb_matrix_c_job_control.sv */
`include "matrix_c_config.svh"

module tb_matrix_c_job_control;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 5;
    localparam int FIELDS    = 6;

    logic clock, rstn, start, busy, done;
    logic [63:0] base_address, cmd_address;
    logic [15:0] size_n, size_tile, ii_start, jj_start;
    logic cmd_request, cmd_grant, resp_valid, job_empty, job_pop;
    logic [4:0] cmd_real_size, resp_real_size;
    logic [15:0] cmd_ii, cmd_jj, resp_ii, resp_jj, job_ii, job_jj;
    logic [`MC_LINE_BITS-1:0] resp_line;
    logic [31:0] job_data;

    logic [63:0] patterns [0:NUM_TESTS*FIELDS-1];
    logic [63:0] exp_cmd_addr[$];
    logic [4:0]  exp_cmd_size[$];
    logic [15:0] exp_cmd_ii[$], exp_cmd_jj[$], exp_job_ii[$], exp_job_jj[$];
    logic [31:0] exp_job_data[$];
    logic [31:0] lfsr_state = 32'h816f;
    int error_count = 0, check_count = 0, cycle_count = 0, cycle_limit = 0;
    int done_count = 0, cmds_granted = 0, cmds_expected = 0;

    tb_clock_gen clock_gen (.clock(clock), .rstn(rstn));

    matrix_c_job_control UUT (
        .clock(clock), .rstn(rstn), .start(start), .base_address(base_address),
        .size_n(size_n), .size_tile(size_tile), .ii_start(ii_start), .jj_start(jj_start),
        .busy(busy), .done(done), .cmd_request(cmd_request), .cmd_grant(cmd_grant),
        .cmd_address(cmd_address), .cmd_real_size(cmd_real_size), .cmd_ii(cmd_ii),
        .cmd_jj(cmd_jj), .resp_valid(resp_valid), .resp_line(resp_line),
        .resp_real_size(resp_real_size), .resp_ii(resp_ii), .resp_jj(resp_jj),
        .job_empty(job_empty), .job_pop(job_pop), .job_ii(job_ii), .job_jj(job_jj),
        .job_data(job_data)
    );

////////////////////////////////////////////////////////////////////////////
// reference rules
////////////////////////////////////////////////////////////////////////////

    // memory content from the word address
    function automatic logic [31:0] memory_word(input logic [63:0] word_addr);
        return word_addr[31:0] ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] reverse_bytes(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    function automatic int clip_end(input int first, input int tile, input int n);
        return (first + tile < n) ? first + tile : n;
    endfunction

    function automatic int tile_area(input int n, input int tile, input int ii0, input int jj0);
        int ii_end, jj_end;
        ii_end = clip_end(ii0, tile, n);
        jj_end = clip_end(jj0, tile, n);
        if (ii_end <= ii0 || jj_end <= jj0) return 0;
        return (ii_end - ii0) * (jj_end - jj0);
    endfunction

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic next_random(input int bits, output int value);
        value = 0;
        for (int b = 0; b < bits; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d in %0d checks", error_count, check_count);
        if (error_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    endtask

    // commands and jobs in row-major order
    task automatic build_expected(input logic [63:0] base, input int n, input int tile,
                                  input int ii0, input int jj0);
        int ii_end, jj_end, size;
        exp_cmd_addr.delete();
        exp_cmd_size.delete();
        exp_cmd_ii.delete();
        exp_cmd_jj.delete();
        ii_end = clip_end(ii0, tile, n);
        jj_end = clip_end(jj0, tile, n);
        for (int ii = ii0; ii < ii_end; ii++) begin
            for (int jj = jj0; jj < jj_end; jj += `MC_LINE_ELEMS) begin
                size = (jj_end - jj < `MC_LINE_ELEMS) ? jj_end - jj : `MC_LINE_ELEMS;
                exp_cmd_addr.push_back(base + 64'((ii * n + jj) * 4));
                exp_cmd_size.push_back(5'(size));
                exp_cmd_ii.push_back(16'(ii));
                exp_cmd_jj.push_back(16'(jj));
                for (int k = 0; k < size; k++) begin
                    exp_job_ii.push_back(16'(ii));
                    exp_job_jj.push_back(16'(jj + k));
                    exp_job_data.push_back(
                        reverse_bytes(memory_word((base >> 2) + 64'(ii * n + jj + k))));
                end
            end
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// memory model and consumer
////////////////////////////////////////////////////////////////////////////

    task automatic serve_commands(input string name, input int n);
        int delay;
        logic [63:0] word;
        for (int i = 0; i < n; i++) begin
            while (!cmd_request) @(negedge clock);
            next_random(3, delay);
            repeat (delay + 1) @(negedge clock);
            check_value({name, " cmd address"}, exp_cmd_addr.pop_front(), cmd_address);
            check_value({name, " cmd real_size"}, exp_cmd_size.pop_front(), cmd_real_size);
            check_value({name, " cmd ii"}, exp_cmd_ii.pop_front(), cmd_ii);
            check_value({name, " cmd jj"}, exp_cmd_jj.pop_front(), cmd_jj);
            word = cmd_address >> 2;
            resp_real_size = cmd_real_size;
            resp_ii = cmd_ii;
            resp_jj = cmd_jj;
            // element 0 sits in the top word of the line
            for (int k = 0; k < `MC_LINE_ELEMS; k++) begin
                resp_line[`MC_LINE_BITS-1-32*k -: 32] = memory_word(word + 64'(k));
            end
            cmd_grant = 1'b1;
            @(negedge clock);
            cmd_grant = 1'b0;
            cmds_granted++;
            next_random(3, delay);
            repeat (delay) @(negedge clock);
            resp_valid = 1'b1;
            @(negedge clock);
            resp_valid = 1'b0;
        end
    endtask

    // stall mode waits for 60 cycles of queued jobs before draining
    task automatic consume_jobs(input string name, input int n, input bit stall);
        int got, low_run;
        bit draining;
        got = 0;
        low_run = 0;
        draining = 1'b0;
        while (got < n) begin
            @(negedge clock);
            job_pop = 1'b0;
            if (job_empty) begin
                low_run = 0;
                draining = 1'b0;
            end else if (!stall || draining) begin
                check_value({name, " job ii"}, exp_job_ii.pop_front(), job_ii);
                check_value({name, " job jj"}, exp_job_jj.pop_front(), job_jj);
                check_value({name, " job data"}, exp_job_data.pop_front(), job_data);
                job_pop = 1'b1;
                got++;
            end else begin
                low_run++;
                if (low_run >= 60) draining = 1'b1;
            end
        end
        @(negedge clock);
        job_pop = 1'b0;
    endtask

    task automatic run_test(input int t);
        logic [63:0] base;
        int n, tile, ii0, jj0, njobs;
        bit stall;
        string name;
        base  = patterns[FIELDS*t];
        n     = int'(patterns[FIELDS*t+1]);
        tile  = int'(patterns[FIELDS*t+2]);
        ii0   = int'(patterns[FIELDS*t+3]);
        jj0   = int'(patterns[FIELDS*t+4]);
        stall = patterns[FIELDS*t+5][0];
        name  = $sformatf("test %0d", t);
        build_expected(base, n, tile, ii0, jj0);
        njobs = exp_job_data.size();
        cmds_expected = exp_cmd_addr.size();
        cmds_granted = 0;
        done_count = 0;
        base_address = base;
        size_n = 16'(n);
        size_tile = 16'(tile);
        ii_start = 16'(ii0);
        jj_start = 16'(jj0);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        check_value({name, " busy after start"}, 1, busy);
        fork
            serve_commands(name, cmds_expected);
            consume_jobs(name, njobs, stall);
        join
        @(negedge clock);
        check_value({name, " busy at end"}, 0, busy);
        check_value({name, " done pulses"}, 1, done_count);
        check_value({name, " job_empty at end"}, 1, job_empty);
        check_value({name, " cmd_request at end"}, 0, cmd_request);
    endtask

////////////////////////////////////////////////////////////////////////////
// monitors
////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (rstn && done) begin
            done_count++;
            if (cmds_granted != cmds_expected) begin
                error_count++;
                $display("done pulsed before the last read command was granted");
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            error_count++;
            $display("timeout: the run hung after %0d cycles", cycle_count);
            finish_run();
        end
    end

    initial begin
        int limit;
        start = 1'b0;
        base_address = '0;
        size_n = '0;
        size_tile = '0;
        ii_start = '0;
        jj_start = '0;
        cmd_grant = 1'b0;
        resp_valid = 1'b0;
        resp_line = '0;
        resp_real_size = '0;
        resp_ii = '0;
        resp_jj = '0;
        job_pop = 1'b0;
        $readmemh("matrix_c_patterns.hex", patterns);
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += 200 + 40 * tile_area(int'(patterns[FIELDS*t+1]),
                int'(patterns[FIELDS*t+2]), int'(patterns[FIELDS*t+3]),
                int'(patterns[FIELDS*t+4]));
        end
        cycle_limit = limit;
        wait (rstn === 1'b1);
        @(negedge clock);
        check_value("reset cmd_request", 0, cmd_request);
        check_value("reset done", 0, done);
        check_value("reset busy", 0, busy);
        check_value("reset job_empty", 1, job_empty);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        finish_run();
    end

endmodule

/* matrix_c_patterns.hex */
// base_address size_n size_tile ii_start jj_start stall
// one test per line, all values in hex
0000000000010000 0020 0010 0000 0000 0
0000000100000000 0014 0010 0008 0008 1
0000000000400040 0028 0018 0004 0003 0
00000000000a0000 000a 0008 0005 0006 1
0000000200001000 0030 0014 001e 001e 1

/* verilog.f */
+incdir+.
matrix_c_pkg.sv
mem_cmd_pkg.sv
matrix_c_ifs.sv
sync_fifo.sv
tile_walker.sv
line_unpacker.sv
matrix_c_job_control.sv
tb_clock_gen.sv
tb_matrix_c_job_control.sv

/* Bender.yml */
package:
  name: matrix_c_job_control

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - matrix_c_pkg.sv
      - mem_cmd_pkg.sv
      - matrix_c_ifs.sv
      - sync_fifo.sv
      - tile_walker.sv
      - line_unpacker.sv
      - matrix_c_job_control.sv
      - target: test
        files:
          - tb_clock_gen.sv
          - tb_matrix_c_job_control.sv
